// ==== filelist.f ====
rtl/timer_pkg.sv
rtl/timer_cfg_if.sv
rtl/timer_regs.sv
rtl/timer_prescaler.sv
rtl/timer_counter.sv
rtl/timer_top.sv
verification/timer_sva.sv
verification/timer_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the timer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

rm -f "$LOG"

verilator --binary --timing --assert \
    --top-module timer_tb \
    --Mdir "$OBJ_DIR" \
    -f filelist.f > "$LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
    cat "$LOG"
    echo "compile failed with status $status"
    exit 1
fi

"./$OBJ_DIR/Vtimer_tb" >> "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi

exit 0

// ==== verification/timer_tb.sv ====
`default_nettype none

module timer_tb;

    import timer_pkg::*;

    localparam int CLK_FREQ = 8;
    // about 110 bus transfers of 3 cycles plus waits, near 450 cycles.
    localparam int TIMEOUT_CYCLES = 4000;

    logic  clk;
    logic  rst;
    logic  sel;
    logic  enable;
    logic  write_en;
    addr_t addr;
    byte_t wdata;
    byte_t rdata;
    logic  ready;

    int cycle_cnt;
    int last_edge;
    int base_edge;
    int errors;
    int checks;
    int seed;

    timer_top #(
        .CLK_FREQ (CLK_FREQ)
    ) i_timer_top (
        .clk_i    (clk),
        .rst      (rst),
        .sel_i    (sel),
        .enable_i (enable),
        .write_i  (write_en),
        .addr_i   (addr),
        .wdata_i  (wdata),
        .rdata_o  (rdata),
        .ready_o  (ready)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Error: run stopped by timeout after %0d cycles", cycle_cnt);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check_equal(string name, byte_t expected, byte_t actual);
        checks++;
        assert (actual == expected) else begin
            $display("Fail %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_cond(bit cond, string what);
        checks++;
        assert (cond) else begin
            $display("Error: %s", what);
            errors++;
        end
    endtask

    // setup cycle, access cycle, then one idle cycle.
    task automatic bus_write(addr_t a, byte_t d);
        @(negedge clk);
        sel      = 1'b1;
        enable   = 1'b0;
        write_en = 1'b1;
        addr     = a;
        wdata    = d;
        @(negedge clk);
        last_edge = cycle_cnt;
        enable    = 1'b1;
        @(negedge clk);
        check_equal("write ready", 8'h01, {7'b0, ready});
        sel      = 1'b0;
        enable   = 1'b0;
        write_en = 1'b0;
    endtask

    task automatic bus_read(addr_t a, output byte_t d);
        @(negedge clk);
        sel      = 1'b1;
        enable   = 1'b0;
        write_en = 1'b0;
        addr     = a;
        @(negedge clk);
        last_edge = cycle_cnt;
        d         = rdata;
        enable    = 1'b1;
        @(negedge clk);
        check_equal("read ready", 8'h01, {7'b0, ready});
        sel    = 1'b0;
        enable = 1'b0;
    endtask

    // count updates visible to a read registered on edge_no.
    // divider leaves zero one edge after base_edge, update follows the tick.
    function automatic int updates_seen(int edge_no);
        int span;
        span = edge_no - base_edge - 2;
        if (span < 0) begin
            return 0;
        end
        return span / CLK_FREQ;
    endfunction

    // down mode with all-ones reload toggles between 0 and all ones.
    function automatic byte_t down_count_byte(int edge_no);
        return (updates_seen(edge_no) % 2 == 1) ? 8'hFF : 8'h00;
    endfunction

    function automatic byte_t reset_read(addr_t a, int edge_no);
        case ({a[7:2], 2'b00})
            ADDR_PRE: return PRE_RESET[8*a[1:0] +: 8];
            ADDR_ARE: return ARE_RESET[8*a[1:0] +: 8];
            ADDR_ENA: return (a[1:0] == 2'b00) ? {7'b0, ENA_RESET} : 8'h00;
            ADDR_CNT: return down_count_byte(edge_no);
            ADDR_EVN: return (a[1:0] == 2'b00) ? byte_t'(updates_seen(edge_no) / 2) : 8'h00;
            default:  return 8'h00;
        endcase
    endfunction

    initial begin
        byte_t rd;
        byte_t cnt_a;
        byte_t cnt_b;
        byte_t evn_a;
        byte_t evn_b;
        byte_t written [8];
        int    rnd;

        clk       = 1'b0;
        rst       = 1'b1;
        sel       = 1'b0;
        enable    = 1'b0;
        write_en  = 1'b0;
        addr      = '0;
        wdata     = '0;
        cycle_cnt = 0;
        last_edge = 0;
        base_edge = 0;
        errors    = 0;
        checks    = 0;
        seed      = 34074;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // timer comes out of reset enabled with the default period.
        base_edge = cycle_cnt;

        // reset values, 0x20 is unmapped.
        for (int a = 0; a <= 32; a++) begin
            bus_read(addr_t'(a), rd);
            check_equal($sformatf("reset read 0x%02h", a), reset_read(addr_t'(a), last_edge), rd);
        end

        // prescale and auto-reload read-back.
        for (int i = 0; i < 8; i++) begin
            rnd        = $random(seed);
            written[i] = rnd[7:0];
            bus_write(ADDR_PRE + addr_t'(i), written[i]);
        end
        for (int i = 0; i < 8; i++) begin
            bus_read(ADDR_PRE + addr_t'(i), rd);
            check_equal($sformatf("read-back 0x%02h", i), written[i], rd);
        end

        // up count, tick every cycle, wrap at 5.
        bus_write(ADDR_CLR, 8'h01);
        bus_write(ADDR_EVC, 8'h01);
        for (int i = 0; i < 4; i++) begin
            bus_write(ADDR_PRE + addr_t'(i), 8'h00);
            bus_write(ADDR_ARE + addr_t'(i), (i == 0) ? 8'h05 : 8'h00);
        end
        bus_write(ADDR_MOD, 8'h01);
        bus_write(ADDR_CLR, 8'h00);
        bus_write(ADDR_EVC, 8'h00);
        for (int i = 0; i < 6; i++) begin
            bus_read(ADDR_CNT, rd);
            check_cond(rd <= 8'd5, "count left the range 0 to 5 in up mode");
        end
        bus_read(ADDR_CNT + 8'd1, rd);
        check_equal("up count byte 1", 8'h00, rd);
        bus_read(ADDR_EVN, evn_a);
        repeat (14) @(negedge clk);
        bus_read(ADDR_EVN, evn_b);
        check_cond(evn_b > evn_a, "event count did not rise across wraps");

        // freeze.
        bus_write(ADDR_ENA, 8'h00);
        repeat (3) @(negedge clk);
        bus_read(ADDR_CNT, cnt_a);
        bus_read(ADDR_EVN, evn_a);
        repeat (20) @(negedge clk);
        bus_read(ADDR_CNT, cnt_b);
        bus_read(ADDR_EVN, evn_b);
        check_equal("frozen count", cnt_a, cnt_b);
        check_equal("frozen events", evn_a, evn_b);

        // clear levels while running.
        bus_write(ADDR_CLR, 8'h01);
        bus_write(ADDR_ENA, 8'h01);
        for (int i = 0; i < 3; i++) begin
            bus_read(ADDR_CNT, rd);
            check_equal("count under clear", 8'h00, rd);
        end
        bus_write(ADDR_EVC, 8'h01);
        bus_read(ADDR_EVN, rd);
        check_equal("events under clear", 8'h00, rd);
        bus_write(ADDR_CLR, 8'h00);
        bus_write(ADDR_EVC, 8'h00);
        repeat (20) @(negedge clk);
        // reads 3 cycles apart differ on a 6-cycle sequence.
        bus_read(ADDR_CNT, cnt_a);
        bus_read(ADDR_CNT, cnt_b);
        check_cond(cnt_a != cnt_b, "count did not resume after clear");
        bus_read(ADDR_EVN, rd);
        check_cond(rd != 8'h00, "event count did not resume after clear");

        // down mode, default period.
        bus_write(ADDR_ENA, 8'h00);
        bus_write(ADDR_CLR, 8'h01);
        bus_write(ADDR_EVC, 8'h01);
        bus_write(ADDR_MOD, 8'h00);
        for (int i = 0; i < 4; i++) begin
            bus_write(ADDR_PRE + addr_t'(i), 8'hFF);
            bus_write(ADDR_ARE + addr_t'(i), 8'hFF);
        end
        bus_write(ADDR_CLR, 8'h00);
        bus_write(ADDR_EVC, 8'h00);
        bus_write(ADDR_ENA, 8'h01);
        base_edge = last_edge;
        repeat (6) @(negedge clk);
        bus_read(ADDR_CNT, rd);
        check_equal("count before first tick", down_count_byte(last_edge), rd);
        bus_read(ADDR_CNT, rd);
        check_equal("count after first tick", down_count_byte(last_edge), rd);
        repeat (2) @(negedge clk);
        bus_read(ADDR_CNT, rd);
        check_equal("count before wrap", down_count_byte(last_edge), rd);
        bus_read(ADDR_CNT, rd);
        check_equal("count after wrap", down_count_byte(last_edge), rd);
        bus_read(ADDR_EVN, rd);
        check_equal("events after wrap", byte_t'(updates_seen(last_edge) / 2), rd);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/timer_sva.sv ====
`default_nettype none

module timer_sva (
    input logic              clk_i,
    input logic              rst,
    input logic              sel_i,
    input logic              enable_i,
    input logic              write_i,
    input timer_pkg::byte_t  rdata_i,
    input logic              ready_i,
    input timer_pkg::word_t  cnt_i,
    input timer_pkg::word_t  are_i,
    input logic              mod_i
);

    // selected bus, ready follows enable one edge later.
    ready_sel_a: assert property (
        @(posedge clk_i) disable iff (rst)
        (!rst && sel_i) |=> (ready_i == $past(enable_i))
    ) else $error("ready_o did not follow enable_i on a selected cycle");

    // idle bus reports ready.
    ready_idle_a: assert property (
        @(posedge clk_i) disable iff (rst)
        (!rst && !sel_i) |=> ready_i
    ) else $error("ready_o low after an idle cycle");

    // read data only after a read setup cycle.
    rdata_idle_a: assert property (
        @(posedge clk_i) disable iff (rst)
        (!rst && !(sel_i && !enable_i && !write_i)) |=> (rdata_i == 8'h00)
    ) else $error("rdata_o not zero outside a read");

    // up mode stays within the reload value.
    cnt_bound_a: assert property (
        @(posedge clk_i) disable iff (rst)
        (mod_i && !(&are_i)) |-> (cnt_i <= are_i)
    ) else $error("count above auto-reload in up mode");

endmodule

bind timer_top timer_sva i_timer_sva (
    .clk_i    (clk_i),
    .rst      (rst),
    .sel_i    (sel_i),
    .enable_i (enable_i),
    .write_i  (write_i),
    .rdata_i  (rdata_o),
    .ready_i  (ready_o),
    .cnt_i    (cnt),
    .are_i    (cfg.are),
    .mod_i    (cfg.mod)
);

`default_nettype wire

// ==== rtl/timer_top.sv ====
`default_nettype none

module timer_top #(
    parameter int unsigned CLK_FREQ = 100
) (
    input  logic              clk_i,
    input  logic              rst,
    input  logic              sel_i,
    input  logic              enable_i,
    input  logic              write_i,
    input  timer_pkg::addr_t  addr_i,
    input  timer_pkg::byte_t  wdata_i,
    output timer_pkg::byte_t  rdata_o,
    output logic              ready_o
);

    import timer_pkg::*;

    logic  tick;
    word_t cnt;
    word_t evn;

    // configuration from the register stage.
    timer_cfg_if cfg ();

    timer_regs i_timer_regs (
        .clk_i    (clk_i),
        .rst      (rst),
        .sel_i    (sel_i),
        .enable_i (enable_i),
        .write_i  (write_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .cnt_i    (cnt),
        .evn_i    (evn),
        .cfg      (cfg.regs_mp),
        .rdata_o  (rdata_o),
        .ready_o  (ready_o)
    );

    timer_prescaler #(
        .CLK_FREQ (CLK_FREQ)
    ) i_timer_prescaler (
        .clk_i  (clk_i),
        .rst    (rst),
        .cfg    (cfg.presc_mp),
        .tick_o (tick)
    );

    // counts flow back to the register stage.
    timer_counter i_timer_counter (
        .clk_i  (clk_i),
        .rst    (rst),
        .tick_i (tick),
        .cfg    (cfg.count_mp),
        .cnt_o  (cnt),
        .evn_o  (evn)
    );

endmodule

`default_nettype wire

// ==== rtl/timer_counter.sv ====
`default_nettype none

module timer_counter (
    input  logic              clk_i,
    input  logic              rst,
    input  logic              tick_i,
    timer_cfg_if.count_mp     cfg,
    output timer_pkg::word_t  cnt_o,
    output timer_pkg::word_t  evn_o
);

    import timer_pkg::*;

    logic  wrap;
    word_t cnt_nxt;
    word_t evn_nxt;

    // auto-reload reached.
    assign wrap = (cnt_o == cfg.are);

    always_comb begin
        cnt_nxt = cnt_o;
        if (tick_i) begin
            if (wrap) begin
                cnt_nxt = '0;
            end else if (cfg.mod) begin
                cnt_nxt = cnt_o + 1'b1;
            end else begin
                cnt_nxt = cnt_o - 1'b1;
            end
        end
        // clear level wins over counting.
        if (cfg.clr) begin
            cnt_nxt = '0;
        end
    end

    always_comb begin
        evn_nxt = evn_o;
        if (tick_i && wrap) begin
            evn_nxt = evn_o + 1'b1;
        end
        if (cfg.evc) begin
            evn_nxt = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            cnt_o <= '0;
            evn_o <= '0;
        end else begin
            cnt_o <= cnt_nxt;
            evn_o <= evn_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/timer_prescaler.sv ====
`default_nettype none

module timer_prescaler #(
    parameter int unsigned CLK_FREQ = 100
) (
    input  logic          clk_i,
    input  logic          rst,
    timer_cfg_if.presc_mp cfg,
    output logic          tick_o
);

    import timer_pkg::*;

    localparam word_t DEFAULT_TERM = word_t'(CLK_FREQ - 1);

    word_t divider;
    word_t terminal;

    always_ff @(posedge clk_i) begin
        if (rst) begin
            terminal <= DEFAULT_TERM;
        end else if (&cfg.pre) begin
            terminal <= DEFAULT_TERM;
        end else begin
            terminal <= cfg.pre;
        end
    end

    // divider runs 0..terminal, so the period is terminal + 1.
    always_ff @(posedge clk_i) begin
        if (rst) begin
            divider <= '0;
            tick_o  <= 1'b0;
        end else if (!cfg.ena) begin
            divider <= '0;
            tick_o  <= 1'b0;
        end else if (divider >= terminal) begin
            divider <= '0;
            tick_o  <= 1'b1;
        end else begin
            divider <= divider + 1'b1;
            tick_o  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/timer_regs.sv ====
`default_nettype none

module timer_regs (
    input  logic              clk_i,
    input  logic              rst,
    input  logic              sel_i,
    input  logic              enable_i,
    input  logic              write_i,
    input  timer_pkg::addr_t  addr_i,
    input  timer_pkg::byte_t  wdata_i,
    input  timer_pkg::word_t  cnt_i,
    input  timer_pkg::word_t  evn_i,
    timer_cfg_if.regs_mp      cfg,
    output timer_pkg::byte_t  rdata_o,
    output logic              ready_o
);

    import timer_pkg::*;

    logic       setup;
    addr_t      word_addr;
    logic [1:0] byte_sel;
    logic       bit_hit;
    byte_t      rdata_nxt;

    // byte lane of a 32-bit field.
    function automatic byte_t pick_byte(word_t value, logic [1:0] sel);
        return value[8*sel +: 8];
    endfunction

    // setup cycle of the strobe bus.
    assign setup     = sel_i & ~enable_i;
    assign word_addr = {addr_i[7:2], 2'b00};
    assign byte_sel  = addr_i[1:0];
    assign bit_hit   = (byte_sel == 2'b00);

    always_ff @(posedge clk_i) begin
        if (rst) begin
            cfg.pre <= PRE_RESET;
            cfg.are <= ARE_RESET;
            cfg.clr <= 1'b0;
            cfg.ena <= ENA_RESET;
            cfg.mod <= 1'b0;
            cfg.evc <= 1'b0;
        end else if (setup && write_i) begin
            case (word_addr)
                ADDR_PRE: cfg.pre[8*byte_sel +: 8] <= wdata_i;
                ADDR_ARE: cfg.are[8*byte_sel +: 8] <= wdata_i;
                ADDR_CLR: begin
                    if (bit_hit) begin
                        cfg.clr <= wdata_i[0];
                    end
                end
                ADDR_ENA: begin
                    if (bit_hit) begin
                        cfg.ena <= wdata_i[0];
                    end
                end
                ADDR_MOD: begin
                    if (bit_hit) begin
                        cfg.mod <= wdata_i[0];
                    end
                end
                ADDR_EVC: begin
                    if (bit_hit) begin
                        cfg.evc <= wdata_i[0];
                    end
                end
                default: ;
            endcase
        end
    end

    // read byte, zero unless a read setup hits a mapped address.
    always_comb begin
        rdata_nxt = '0;
        if (setup && !write_i) begin
            case (word_addr)
                ADDR_PRE: rdata_nxt = pick_byte(cfg.pre, byte_sel);
                ADDR_ARE: rdata_nxt = pick_byte(cfg.are, byte_sel);
                ADDR_CNT: rdata_nxt = pick_byte(cnt_i, byte_sel);
                ADDR_EVN: rdata_nxt = pick_byte(evn_i, byte_sel);
                ADDR_CLR: rdata_nxt = {7'b0, cfg.clr & bit_hit};
                ADDR_ENA: rdata_nxt = {7'b0, cfg.ena & bit_hit};
                ADDR_MOD: rdata_nxt = {7'b0, cfg.mod & bit_hit};
                ADDR_EVC: rdata_nxt = {7'b0, cfg.evc & bit_hit};
                default:  rdata_nxt = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            rdata_o <= '0;
            ready_o <= 1'b0;
        end else begin
            rdata_o <= rdata_nxt;
            // idle bus reports ready.
            ready_o <= sel_i ? enable_i : 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/timer_cfg_if.sv ====
`default_nettype none

interface timer_cfg_if;

    import timer_pkg::*;

    word_t pre;
    word_t are;
    logic  clr;
    logic  ena;
    logic  mod;
    logic  evc;

    modport regs_mp (
        output pre,
        output are,
        output clr,
        output ena,
        output mod,
        output evc
    );

    // divider side.
    modport presc_mp (
        input pre,
        input ena
    );

    // count side.
    modport count_mp (
        input are,
        input clr,
        input mod,
        input evc
    );

endinterface

`default_nettype wire

// ==== rtl/timer_pkg.sv ====
`default_nettype none

package timer_pkg;

    // value widths.
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  addr_t;

    // register map, word fields take four byte addresses from the base.
    localparam addr_t ADDR_PRE = 8'h00;
    localparam addr_t ADDR_ARE = 8'h04;
    localparam addr_t ADDR_CLR = 8'h08;
    localparam addr_t ADDR_ENA = 8'h0C;
    localparam addr_t ADDR_MOD = 8'h10;
    localparam addr_t ADDR_CNT = 8'h14;
    localparam addr_t ADDR_EVN = 8'h18;
    localparam addr_t ADDR_EVC = 8'h1C;

    // all ones in prescale selects the default period.
    localparam word_t PRE_RESET = 32'hFFFF_FFFF;
    localparam word_t ARE_RESET = 32'hFFFF_FFFF;
    localparam logic  ENA_RESET = 1'b1;

endpackage

`default_nettype wire
